//--- sim.f
verilog/soc_map_pkg.sv
verilog/soc_bus_pkg.sv
verilog/sys_ctrl.sv
verilog/axil_decoder.sv
verilog/dev_table.sv
verilog/gpio_port.sv
verilog/int_ctrl.sv
verilog/soc_top.sv
sim/soc_assertions.sv
sim/tb_soc.sv

//--- Makefile
# Verilator build and run for the system control testbench

VERILATOR ?= verilator
TOP       ?= tb_soc
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_soc.sv
// Testbench for the system control top level
`timescale 1ns/1ps
`default_nettype none

module tb_soc;

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	localparam int          RST_BITS       = 5;
	localparam int          ACT_BITS       = 4;
	localparam int          GPIO_N         = 16;
	localparam int          N_RAND         = 24;
	localparam int unsigned SEED           = 32'h38061c1a;
	localparam int          TIMEOUT_CYCLES = 20000; // The full run needs a few thousand cycles.

	logic              clk100mhz;
	logic              rst_p;
	axil_req_t         req;
	axil_rsp_t         rsp;
	logic [GPIO_N-1:0] gp_i;
	logic [GPIO_N-1:0] gp_o;
	logic              ext_irq;
	logic              irq;
	logic              rst_out;
	logic              activity;
	int                cycles = 0;
	int                act_pulses = 0;
	logic [GPIO_N-1:0] m_out;
	logic [GPIO_N-1:0] m_ien;
	logic [1:0]        m_pend;
	logic [1:0]        m_en;

	soc_top #(
		.RST_CNTR_BITSZ (RST_BITS),
		.ACT_CNTR_BITSZ (ACT_BITS),
		.GPIO_COUNT     (GPIO_N),
		.INT_SRC_COUNT  (2)
	) dut0 (
		.clk100mhz  (clk100mhz),
		.rst_p      (rst_p),
		.axil_req_i (req),
		.axil_rsp_o (rsp),
		.gp_i       (gp_i),
		.gp_o       (gp_o),
		.ext_irq_i  (ext_irq),
		.irq_o      (irq),
		.rst_out_o  (rst_out),
		.activity_o (activity)
	);

	bind soc_top soc_assertions assertions0 (
		.clk100mhz  (clk100mhz),
		.sys_rst_i  (sys_rst),
		.axil_req_i (axil_req_i),
		.axil_rsp_i (axil_rsp_o),
		.activity_i (activity_o)
	);

	initial begin
		clk100mhz = 1'b0;
		forever #5 clk100mhz = ~clk100mhz;
	end

	always @(posedge clk100mhz) begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			fail_run();
		end else if (dut0.assertions0.fail_count != 0) begin
			$display("a bound assertion on the bus or the activity output failed");
			fail_run();
		end
	end

	always @(negedge clk100mhz) begin
		if (activity)
			act_pulses = act_pulses + 1;
	end

	task automatic fail_run();
		$display("Some tests failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_word(input string name, input data_t exp, input data_t act);
		if (exp !== act) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
		if (exp !== act) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("mismatch %s expected %b actual %b", name, exp, act);
			fail_run();
		end
	endtask

	function automatic addr_t reg_addr(input int slot, input logic [7:0] off);
		return addr_t'(slot << SLOT_BITS) | addr_t'({off, 2'b00});
	endfunction

	function automatic int rand_delay();
		return int'($urandom_range(3, 0));
	endfunction

	// Bytes 0 and 1 of the write land only where their strobe is set.
	function automatic logic [15:0] merge16(input logic [15:0] old, input data_t wd,
		input strb_t st);
		logic [15:0] mask;
		mask = {{8{st[1]}}, {8{st[0]}}};
		return (old & ~mask) | (wd[15:0] & mask);
	endfunction

	task automatic next_cycles(input int n);
		repeat (n) @(posedge clk100mhz);
		#1;
	endtask

	task automatic wait_reset_end();
		@(negedge clk100mhz);
		while (rst_out)
			@(negedge clk100mhz);
		@(posedge clk100mhz);
		#1;
	endtask

	task automatic bus_write(input addr_t addr, input data_t wd, input strb_t st, input int delay);
		req.aw_valid = 1'b1;
		req.aw_addr  = addr;
		req.w_valid  = 1'b1;
		req.w_data   = wd;
		req.w_strb   = st;
		@(negedge clk100mhz);
		while (!rsp.aw_ready)
			@(negedge clk100mhz);
		check_bit("w ready with aw ready", 1'b1, rsp.w_ready);
		@(posedge clk100mhz);
		#1;
		req.aw_valid = 1'b0;
		req.w_valid  = 1'b0;
		req.b_ready  = (delay == 0);
		@(negedge clk100mhz);
		check_bit("write response one cycle after handshake", 1'b1, rsp.b_valid);
		check_resp("write response code", AXIL_OKAY, rsp.b_resp);
		if (delay > 0) begin
			repeat (delay) @(posedge clk100mhz);
			#1;
			req.b_ready = 1'b1;
		end
		@(posedge clk100mhz);
		#1;
		req.b_ready = 1'b0;
	endtask

	task automatic bus_read(input addr_t addr, input int delay, output data_t rd);
		req.ar_valid = 1'b1;
		req.ar_addr  = addr;
		@(negedge clk100mhz);
		while (!rsp.ar_ready)
			@(negedge clk100mhz);
		@(posedge clk100mhz);
		#1;
		req.ar_valid = 1'b0;
		req.r_ready  = (delay == 0);
		@(negedge clk100mhz);
		check_bit("read response one cycle after handshake", 1'b1, rsp.r_valid);
		check_resp("read response code", AXIL_OKAY, rsp.r_resp);
		rd = rsp.r_data; // Held stable until the host takes it.
		if (delay > 0) begin
			repeat (delay) @(posedge clk100mhz);
			#1;
			req.r_ready = 1'b1;
		end
		@(posedge clk100mhz);
		#1;
		req.r_ready = 1'b0;
	endtask

	task automatic read_check(input string name, input addr_t addr, input data_t exp);
		data_t rd;
		bus_read(addr, rand_delay(), rd);
		check_word(name, exp, rd);
	endtask

	initial begin
		data_t       wd;
		strb_t       st;
		addr_t       ad;
		logic [15:0] flips;
		logic [1:0]  clr;
		int          high_cycles;
		int          base;
		void'($urandom(SEED));
		rst_p   = 1'b1;
		req     = '0;
		gp_i    = '0;
		ext_irq = 1'b0;
		m_out   = '0;
		m_ien   = '0;
		m_pend  = '0;
		m_en    = '0;
		repeat (4) @(posedge clk100mhz);
		#1;
		rst_p = 1'b0;
		wait_reset_end();

		for (int k = 0; k < SLOT_COUNT; k++) begin
			read_check("device id", reg_addr(SLOT_DEVTBL, 8'(2 * k)), data_t'(DEV_ID[k]));
			read_check("device map size", reg_addr(SLOT_DEVTBL, 8'(2 * k + 1)),
				{DEV_USEINTR[k], 31'(DEV_MAPSZ[k])});
		end

		repeat (N_RAND) begin
			wd = $urandom();
			st = strb_t'($urandom_range(15, 0));
			bus_write(reg_addr(SLOT_GPIO, REG_GPIO_OUT), wd, st, rand_delay());
			m_out = merge16(m_out, wd, st);
			read_check("gpio output readback", reg_addr(SLOT_GPIO, REG_GPIO_OUT), data_t'(m_out));
			check_word("gpio output pins", data_t'(m_out), data_t'(gp_o));
		end

		repeat (8) begin
			gp_i = 16'($urandom());
			next_cycles(3);
			read_check("gpio input", reg_addr(SLOT_GPIO, REG_GPIO_IN), data_t'(gp_i));
		end

		wd = $urandom();
		bus_write(reg_addr(SLOT_GPIO, REG_GPIO_IEN), wd, 4'hf, rand_delay());
		m_ien = merge16(m_ien, wd, 4'hf);
		repeat (N_RAND) begin
			wd = $urandom();
			bus_write(reg_addr(SLOT_INTCTRL, REG_INT_EN), wd, 4'hf, rand_delay());
			m_en = wd[1:0];
			if ($urandom_range(1, 0) == 1) begin
				flips = 16'($urandom());
				if ((flips & m_ien) != 16'h0)
					m_pend[INT_SRC_GPIO] = 1'b1;
				gp_i = gp_i ^ flips;
			end else begin
				ext_irq = 1'b1;
				m_pend[INT_SRC_EXT] = 1'b1;
			end
			next_cycles(2);
			ext_irq = 1'b0;
			next_cycles(4); // Covers the two synchronizer stages and the request register.
			check_bit("irq output", |(m_pend & m_en), irq);
			read_check("pending bits", reg_addr(SLOT_INTCTRL, REG_INT_PEND), data_t'(m_pend));
			clr = 2'($urandom());
			bus_write(reg_addr(SLOT_INTCTRL, REG_INT_PEND), data_t'(clr), 4'hf, rand_delay());
			m_pend = m_pend & ~clr;
			check_bit("irq after clear", |(m_pend & m_en), irq);
		end

		// Low offsets alias live registers if the slot is decoded wrongly.
		repeat (N_RAND) begin
			ad = reg_addr(int'($urandom_range(15, 3)), 8'($urandom_range(7, 0)));
			read_check("invalid slot read", ad, '0);
			bus_write(ad, $urandom(), 4'hf, rand_delay());
		end
		read_check("gpio output after invalid writes", reg_addr(SLOT_GPIO, REG_GPIO_OUT),
			data_t'(m_out));
		read_check("gpio enable after invalid writes", reg_addr(SLOT_GPIO, REG_GPIO_IEN),
			data_t'(m_ien));
		read_check("irq enable after invalid writes", reg_addr(SLOT_INTCTRL, REG_INT_EN),
			data_t'(m_en));
		read_check("pending after invalid writes", reg_addr(SLOT_INTCTRL, REG_INT_PEND),
			data_t'(m_pend));

		bus_write(reg_addr(SLOT_DEVTBL, REG_RSTCMD), 32'h2, 4'h1, 0);
		high_cycles = 0;
		@(negedge clk100mhz);
		while (rst_out) begin
			high_cycles++;
			@(negedge clk100mhz);
		end
		check_word("warm reset length", data_t'((1 << RST_BITS) - 1), data_t'(high_cycles));
		@(posedge clk100mhz);
		#1;
		m_out  = '0;
		m_ien  = '0;
		m_pend = '0;
		m_en   = '0;
		base   = act_pulses;
		read_check("gpio output after warm reset", reg_addr(SLOT_GPIO, REG_GPIO_OUT),
			data_t'(m_out));
		next_cycles((1 << ACT_BITS) + 4);
		check_word("activity pulse count", 32'd1, data_t'(act_pulses - base));

		bus_write(reg_addr(SLOT_DEVTBL, REG_RSTCMD), 32'h1, 4'h1, 0);
		repeat (4 * (1 << RST_BITS)) begin
			@(negedge clk100mhz);
			check_bit("power-off holds reset", 1'b1, rst_out);
		end
		@(posedge clk100mhz);
		#1;
		rst_p = 1'b1;
		next_cycles(4);
		rst_p = 1'b0;
		wait_reset_end();
		read_check("bus after power-off release", reg_addr(SLOT_DEVTBL, 8'd0),
			data_t'(DEV_ID[SLOT_DEVTBL]));

		if (dut0.assertions0.fail_count != 0) begin
			$display("a bound assertion on the bus or the activity output failed");
			fail_run();
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sim/soc_assertions.sv
// Bus handshake and activity checks
`timescale 1ns/1ps
`default_nettype none

module soc_assertions (
	input wire                         clk100mhz,
	input wire                         sys_rst_i,
	input wire soc_bus_pkg::axil_req_t axil_req_i,
	input wire soc_bus_pkg::axil_rsp_t axil_rsp_i,
	input wire                         activity_i
);

	int unsigned fail_count = 0;

	b_hold: assert property (@(posedge clk100mhz) disable iff (sys_rst_i)
		axil_rsp_i.b_valid && !axil_req_i.b_ready
		|=> axil_rsp_i.b_valid && $stable(axil_rsp_i.b_resp))
	else begin
		fail_count++;
		$error("write response dropped or changed before acceptance");
	end

	r_hold: assert property (@(posedge clk100mhz) disable iff (sys_rst_i)
		axil_rsp_i.r_valid && !axil_req_i.r_ready
		|=> axil_rsp_i.r_valid && $stable(axil_rsp_i.r_data) && $stable(axil_rsp_i.r_resp))
	else begin
		fail_count++;
		$error("read response dropped or changed before acceptance");
	end

	// A response only follows the address handshake of the cycle before.
	b_cause: assert property (@(posedge clk100mhz) disable iff (sys_rst_i)
		$rose(axil_rsp_i.b_valid) |-> $past(axil_req_i.aw_valid && axil_rsp_i.aw_ready))
	else begin
		fail_count++;
		$error("write response without a write address handshake");
	end

	r_cause: assert property (@(posedge clk100mhz) disable iff (sys_rst_i)
		$rose(axil_rsp_i.r_valid) |-> $past(axil_req_i.ar_valid && axil_rsp_i.ar_ready))
	else begin
		fail_count++;
		$error("read response without a read address handshake");
	end

	act_quiet: assert property (@(posedge clk100mhz) sys_rst_i |-> !activity_i)
	else begin
		fail_count++;
		$error("activity output high during reset");
	end

endmodule

`default_nettype wire

//--- verilog/soc_top.sv
// System control top level
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
	parameter int RST_CNTR_BITSZ = 16,
	parameter int ACT_CNTR_BITSZ = 7,
	parameter int GPIO_COUNT     = 16,
	parameter int INT_SRC_COUNT  = 2
) (
	input wire                         clk100mhz,
	input wire                         rst_p,
	input wire soc_bus_pkg::axil_req_t axil_req_i,
	output soc_bus_pkg::axil_rsp_t     axil_rsp_o,
	input wire [GPIO_COUNT-1:0]        gp_i,
	output logic [GPIO_COUNT-1:0]      gp_o,
	input wire                         ext_irq_i,
	output logic                       irq_o,
	output logic                       rst_out_o,
	output logic                       activity_o
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic                     sys_rst;
	logic                     xfer_done;
	logic [1:0]               rst_cmd;
	dev_req_t                 dev_req;
	logic [SLOT_COUNT-1:0]    dev_sel;
	wire data_t               dev_rdata [SLOT_COUNT-1];
	logic                     gpio_intrqst;
	wire [INT_SRC_COUNT-1:0]  int_src;

	assign int_src[INT_SRC_GPIO] = gpio_intrqst;
	assign int_src[INT_SRC_EXT]  = ext_irq_i;

	sys_ctrl #(
		 .RST_CNTR_BITSZ (RST_CNTR_BITSZ)
		,.ACT_CNTR_BITSZ (ACT_CNTR_BITSZ)
	) sys_ctrl0 (
		 .clk100mhz   (clk100mhz)
		,.rst_p       (rst_p)
		,.rst_cmd_i   (rst_cmd)
		,.xfer_done_i (xfer_done)
		,.sys_rst_o   (sys_rst)
		,.rst_out_o   (rst_out_o)
		,.activity_o  (activity_o)
	);

	axil_decoder axil_decoder0 (
		 .clk100mhz   (clk100mhz)
		,.sys_rst_i   (sys_rst)
		,.axil_req_i  (axil_req_i)
		,.axil_rsp_o  (axil_rsp_o)
		,.dev_req_o   (dev_req)
		,.dev_sel_o   (dev_sel)
		,.dev_rdata_i (dev_rdata)
		,.xfer_done_o (xfer_done)
	);

	dev_table dev_table0 (
		 .clk100mhz (clk100mhz)
		,.sys_rst_i (sys_rst)
		,.dev_req_i (dev_req)
		,.sel_i     (dev_sel[SLOT_DEVTBL])
		,.rdata_o   (dev_rdata[SLOT_DEVTBL])
		,.rst_cmd_o (rst_cmd)
	);

	gpio_port #(
		.GPIO_COUNT (GPIO_COUNT)
	) gpio_port0 (
		 .clk100mhz (clk100mhz)
		,.sys_rst_i (sys_rst)
		,.dev_req_i (dev_req)
		,.sel_i     (dev_sel[SLOT_GPIO])
		,.gp_i      (gp_i)
		,.gp_o      (gp_o)
		,.rdata_o   (dev_rdata[SLOT_GPIO])
		,.intrqst_o (gpio_intrqst)
	);

	int_ctrl #(
		.INT_SRC_COUNT (INT_SRC_COUNT)
	) int_ctrl0 (
		 .clk100mhz (clk100mhz)
		,.sys_rst_i (sys_rst)
		,.dev_req_i (dev_req)
		,.sel_i     (dev_sel[SLOT_INTCTRL])
		,.src_i     (int_src)
		,.rdata_o   (dev_rdata[SLOT_INTCTRL])
		,.irq_o     (irq_o)
	);

endmodule

`default_nettype wire

//--- verilog/int_ctrl.sv
// Interrupt controller
`timescale 1ns/1ps
`default_nettype none

module int_ctrl #(
	parameter int INT_SRC_COUNT = 2
) (
	input wire                        clk100mhz,
	input wire                        sys_rst_i,
	input wire soc_bus_pkg::dev_req_t dev_req_i,
	input wire                        sel_i,
	input wire [INT_SRC_COUNT-1:0]    src_i,
	output soc_bus_pkg::data_t        rdata_o,
	output logic                      irq_o
);

	import soc_map_pkg::*;

	logic [INT_SRC_COUNT-1:0] src_q;
	logic [INT_SRC_COUNT-1:0] pend_q;
	logic [INT_SRC_COUNT-1:0] en_q;
	logic [INT_SRC_COUNT-1:0] rise;
	logic [INT_SRC_COUNT-1:0] wmask;
	logic [INT_SRC_COUNT-1:0] wbits;
	logic                     wr_en;

	always_comb begin
		for (int i = 0; i < INT_SRC_COUNT; i++)
			wmask[i] = dev_req_i.strb[i / 8];
	end

	assign wr_en = sel_i && dev_req_i.wr;
	assign wbits = dev_req_i.wdata[INT_SRC_COUNT-1:0] & wmask;
	assign rise  = src_i & ~src_q;

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			src_q  <= '0;
			pend_q <= '0;
			en_q   <= '0;
		end else begin
			src_q <= src_i;
			if (wr_en && dev_req_i.offset == REG_INT_PEND)
				pend_q <= (pend_q & ~wbits) | rise; // A new request beats the clear.
			else
				pend_q <= pend_q | rise;
			if (wr_en && dev_req_i.offset == REG_INT_EN)
				en_q <= (en_q & ~wmask) | wbits;
		end
	end

	always_comb begin
		rdata_o = '0;
		case (dev_req_i.offset)
			REG_INT_PEND: rdata_o[INT_SRC_COUNT-1:0] = pend_q;
			REG_INT_EN:   rdata_o[INT_SRC_COUNT-1:0] = en_q;
			default:      rdata_o = '0;
		endcase
	end

	assign irq_o = |(pend_q & en_q);

endmodule

`default_nettype wire

//--- verilog/gpio_port.sv
// GPIO port with change interrupt
`timescale 1ns/1ps
`default_nettype none

module gpio_port #(
	parameter int GPIO_COUNT = 16
) (
	input wire                        clk100mhz,
	input wire                        sys_rst_i,
	input wire soc_bus_pkg::dev_req_t dev_req_i,
	input wire                        sel_i,
	input wire [GPIO_COUNT-1:0]       gp_i,
	output logic [GPIO_COUNT-1:0]     gp_o,
	output soc_bus_pkg::data_t        rdata_o,
	output logic                      intrqst_o
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic [GPIO_COUNT-1:0] sync1_q;
	logic [GPIO_COUNT-1:0] sync2_q;
	logic [GPIO_COUNT-1:0] out_q;
	logic [GPIO_COUNT-1:0] ien_q;
	logic                  intrqst_q;
	logic                  wr_en;

	function automatic logic [GPIO_COUNT-1:0] byte_merge(
		input logic [GPIO_COUNT-1:0] old_val,
		input data_t                 wdata,
		input strb_t                 strb
	);
		logic [GPIO_COUNT-1:0] res;
		res = old_val;
		for (int i = 0; i < GPIO_COUNT; i++) begin
			if (strb[i / 8])
				res[i] = wdata[i];
		end
		return res;
	endfunction

	assign wr_en = sel_i && dev_req_i.wr;

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			sync1_q   <= '0;
			sync2_q   <= '0;
			out_q     <= '0;
			ien_q     <= '0;
			intrqst_q <= 1'b0;
		end else begin
			sync1_q   <= gp_i;
			sync2_q   <= sync1_q;
			intrqst_q <= |((sync1_q ^ sync2_q) & ien_q); // Fires as stage two takes the change.
			if (wr_en && dev_req_i.offset == REG_GPIO_OUT)
				out_q <= byte_merge(out_q, dev_req_i.wdata, dev_req_i.strb);
			if (wr_en && dev_req_i.offset == REG_GPIO_IEN)
				ien_q <= byte_merge(ien_q, dev_req_i.wdata, dev_req_i.strb);
		end
	end

	always_comb begin
		rdata_o = '0;
		case (dev_req_i.offset)
			REG_GPIO_IN:  rdata_o[GPIO_COUNT-1:0] = sync2_q;
			REG_GPIO_OUT: rdata_o[GPIO_COUNT-1:0] = out_q;
			REG_GPIO_IEN: rdata_o[GPIO_COUNT-1:0] = ien_q;
			default:      rdata_o = '0;
		endcase
	end

	assign gp_o      = out_q;
	assign intrqst_o = intrqst_q;

endmodule

`default_nettype wire

//--- verilog/dev_table.sv
// Device table
`timescale 1ns/1ps
`default_nettype none

module dev_table (
	input wire                        clk100mhz,
	input wire                        sys_rst_i,
	input wire soc_bus_pkg::dev_req_t dev_req_i,
	input wire                        sel_i,
	output soc_bus_pkg::data_t        rdata_o,
	output logic [1:0]                rst_cmd_o
);

	import soc_map_pkg::*;

	localparam int IDX_W = $clog2(SLOT_COUNT);

	logic [IDX_W-1:0] slot_idx;
	logic             in_table;
	logic             cmd_wr;
	logic [1:0]       rst_cmd_q;

	assign slot_idx = dev_req_i.offset[1 +: IDX_W]; // Two words per slot.
	assign in_table = (dev_req_i.offset < 8'(2 * SLOT_COUNT));

	always_comb begin
		rdata_o = '0;
		if (in_table) begin
			if (dev_req_i.offset[0])
				rdata_o = {DEV_USEINTR[slot_idx], DEV_MAPSZ[slot_idx][30:0]};
			else
				rdata_o = DEV_ID[slot_idx];
		end
	end

	assign cmd_wr = sel_i && dev_req_i.wr && dev_req_i.strb[0]
		&& (dev_req_i.offset == REG_RSTCMD);

	// The command is a single-cycle pulse toward the reset sequencer.
	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i)
			rst_cmd_q <= '0;
		else if (cmd_wr)
			rst_cmd_q <= dev_req_i.wdata[1:0];
		else
			rst_cmd_q <= '0;
	end

	assign rst_cmd_o = rst_cmd_q;

endmodule

`default_nettype wire

//--- verilog/axil_decoder.sv
// AXI4-Lite slave and slot decoder
`timescale 1ns/1ps
`default_nettype none

module axil_decoder (
	input wire                                 clk100mhz,
	input wire                                 sys_rst_i,
	input wire soc_bus_pkg::axil_req_t         axil_req_i,
	output soc_bus_pkg::axil_rsp_t             axil_rsp_o,
	output soc_bus_pkg::dev_req_t              dev_req_o,
	output logic [soc_map_pkg::SLOT_COUNT-1:0] dev_sel_o,
	input wire soc_bus_pkg::data_t             dev_rdata_i [soc_map_pkg::SLOT_COUNT-1],
	output logic                               xfer_done_o
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	localparam int SLOT_W = $clog2(SLOT_COUNT);
	localparam int RAW_W  = $bits(addr_t) - SLOT_BITS;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRESP,
		ST_RRESP
	} state_t;

	state_t            state_q;
	data_t             rdata_q;
	data_t             rdata_mux;
	addr_t             addr;
	logic [RAW_W-1:0]  raw_slot;
	logic [SLOT_W-1:0] slot;
	logic              idle;
	logic              accept_wr;
	logic              accept_rd;

	assign idle      = (state_q == ST_IDLE) && !sys_rst_i; // No ready while in reset.
	assign accept_wr = idle && axil_req_i.aw_valid && axil_req_i.w_valid;
	assign accept_rd = idle && axil_req_i.ar_valid
		&& !axil_req_i.aw_valid && !axil_req_i.w_valid; // Writes take precedence.

	assign addr     = accept_wr ? axil_req_i.aw_addr : axil_req_i.ar_addr;
	assign raw_slot = addr[$bits(addr_t)-1:SLOT_BITS];
	assign slot     = (raw_slot >= RAW_W'(SLOT_INVALID)) ? SLOT_W'(SLOT_INVALID)
		: raw_slot[SLOT_W-1:0];

	always_comb begin
		dev_req_o.wr     = accept_wr;
		dev_req_o.rd     = accept_rd;
		dev_req_o.offset = addr[2 +: $bits(dev_off_t)]; // Byte address to word offset.
		dev_req_o.wdata  = axil_req_i.w_data;
		dev_req_o.strb   = axil_req_i.w_strb;
	end

	// The invalid slot has no device behind it and so reads as zero.
	always_comb begin
		dev_sel_o       = '0;
		dev_sel_o[slot] = 1'b1;
		rdata_mux       = '0;
		for (int k = 0; k < SLOT_COUNT - 1; k++) begin
			if (dev_sel_o[k])
				rdata_mux = rdata_mux | dev_rdata_i[k];
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			state_q <= ST_IDLE;
			rdata_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (accept_wr) begin
						state_q <= ST_WRESP;
					end else if (accept_rd) begin
						state_q <= ST_RRESP;
						rdata_q <= rdata_mux; // Sampled in the acceptance cycle.
					end
				end
				ST_WRESP: begin
					if (axil_req_i.b_ready)
						state_q <= ST_IDLE;
				end
				ST_RRESP: begin
					if (axil_req_i.r_ready)
						state_q <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_comb begin
		axil_rsp_o          = '0;
		axil_rsp_o.aw_ready = accept_wr;
		axil_rsp_o.w_ready  = accept_wr;
		axil_rsp_o.b_valid  = (state_q == ST_WRESP);
		axil_rsp_o.b_resp   = AXIL_OKAY;
		axil_rsp_o.ar_ready = accept_rd;
		axil_rsp_o.r_valid  = (state_q == ST_RRESP);
		axil_rsp_o.r_data   = rdata_q;
		axil_rsp_o.r_resp   = AXIL_OKAY;
	end

	assign xfer_done_o = (axil_rsp_o.b_valid && axil_req_i.b_ready)
		|| (axil_rsp_o.r_valid && axil_req_i.r_ready);

endmodule

`default_nettype wire

//--- verilog/sys_ctrl.sv
// Reset sequencing and activity indicator
`timescale 1ns/1ps
`default_nettype none

module sys_ctrl #(
	parameter int RST_CNTR_BITSZ = 16,
	parameter int ACT_CNTR_BITSZ = 7
) (
	input wire         clk100mhz,
	input wire         rst_p,
	input wire [1:0]   rst_cmd_i,
	input wire         xfer_done_i,
	output logic       sys_rst_o,
	output logic       rst_out_o,
	output logic       activity_o
);

	logic [RST_CNTR_BITSZ-1:0] rst_cntr_q;
	logic [RST_CNTR_BITSZ-1:0] rst_cntr_d;
	logic [ACT_CNTR_BITSZ-1:0] act_cntr_q;
	logic                      pwroff_q;
	logic                      pwroff_d;
	logic                      act_q;
	logic                      warm_cmd;
	logic                      pwroff_cmd;
	logic                      sys_rst_d;

	assign warm_cmd   = rst_cmd_i[1]; // A cold command lands here too.
	assign pwroff_cmd = rst_cmd_i[0] & ~rst_cmd_i[1];

	always_comb begin
		rst_cntr_d = rst_cntr_q;
		if (rst_p || warm_cmd)
			rst_cntr_d = '1;
		else if (|rst_cntr_q)
			rst_cntr_d = rst_cntr_q - 1'b1;
		pwroff_d  = rst_p ? 1'b0 : (pwroff_q | pwroff_cmd); // Only the external reset unlatches.
		sys_rst_d = (|rst_cntr_d) | pwroff_d;
	end

	always_ff @(posedge clk100mhz) begin
		rst_cntr_q <= rst_cntr_d;
		pwroff_q   <= pwroff_d;
	end

	// The stretcher looks one cycle ahead so no pulse overlaps the reset window.
	always_ff @(posedge clk100mhz) begin
		if (sys_rst_d) begin
			act_q      <= 1'b0;
			act_cntr_q <= '0;
		end else if (|act_cntr_q) begin
			act_q      <= 1'b0;
			act_cntr_q <= act_cntr_q - 1'b1;
		end else begin
			act_q <= xfer_done_i;
			if (xfer_done_i)
				act_cntr_q <= '1; // Hold-off before the next pulse.
		end
	end

	assign sys_rst_o  = (|rst_cntr_q) | pwroff_q;
	assign rst_out_o  = sys_rst_o;
	assign activity_o = act_q;

endmodule

`default_nettype wire

//--- verilog/soc_bus_pkg.sv
// Host bus and device request types
`default_nettype none

package soc_bus_pkg;

	typedef logic [31:0] data_t;
	typedef logic [15:0] addr_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  axil_resp_t;
	typedef logic [7:0]  dev_off_t; // Word offset inside one slot.

	localparam axil_resp_t AXIL_OKAY = 2'b00;

	typedef struct packed {
		logic  aw_valid;
		addr_t aw_addr;
		logic  w_valid;
		data_t w_data;
		strb_t w_strb;
		logic  b_ready;
		logic  ar_valid;
		addr_t ar_addr;
		logic  r_ready;
	} axil_req_t;

	typedef struct packed {
		logic       aw_ready;
		logic       w_ready;
		logic       b_valid;
		axil_resp_t b_resp;
		logic       ar_ready;
		logic       r_valid;
		data_t      r_data;
		axil_resp_t r_resp;
	} axil_rsp_t;

	typedef struct packed {
		logic     wr;
		logic     rd;
		dev_off_t offset;
		data_t    wdata;
		strb_t    strb;
	} dev_req_t;

endpackage

`default_nettype wire

//--- verilog/soc_map_pkg.sv
// System address map
`default_nettype none

package soc_map_pkg;

	localparam int unsigned SLOT_BITS = 12; // Slot index occupies address bits 15:12.

	localparam int unsigned SLOT_DEVTBL  = 0;
	localparam int unsigned SLOT_GPIO    = 1;
	localparam int unsigned SLOT_INTCTRL = 2;
	localparam int unsigned SLOT_INVALID = 3; // Also catches every higher slot.
	localparam int unsigned SLOT_COUNT   = 4;

	localparam int unsigned DEV_ID [SLOT_COUNT] = '{7, 6, 3, 0};
	localparam int unsigned DEV_MAPSZ [SLOT_COUNT] = '{1024, 1024, 1024, 1024}; // In words.
	localparam bit DEV_USEINTR [SLOT_COUNT] = '{1'b0, 1'b1, 1'b0, 1'b0};

	localparam logic [7:0] REG_RSTCMD = 8'd64;

	localparam logic [7:0] REG_GPIO_IN  = 8'd0;
	localparam logic [7:0] REG_GPIO_OUT = 8'd1;
	localparam logic [7:0] REG_GPIO_IEN = 8'd2;

	localparam logic [7:0] REG_INT_PEND = 8'd0;
	localparam logic [7:0] REG_INT_EN   = 8'd1;

	localparam int unsigned INT_SRC_GPIO = 0;
	localparam int unsigned INT_SRC_EXT  = 1;

endpackage

`default_nettype wire
